//--- logic/fdc_pkg.sv
// fdc_pkg
// shared widths, register map, command codes, fixed disk geometry
// and state encodings for the WD1793-style floppy controller
package fdc_pkg;

	typedef logic [7:0]  fdc_byte_t;
	typedef logic [1:0]  fdc_addr_t;
	typedef logic [19:0] img_addr_t;  // byte offset in image, 1 MiB max
	typedef logic [10:0] buf_addr_t;
	typedef logic [31:0] lba_t;
	typedef logic [1:0]  blk_idx_t;
	typedef logic [8:0]  sd_off_t;
	typedef logic [10:0] byte_cnt_t;
	typedef logic [2:0]  size_sel_t;

	localparam fdc_addr_t reg_status = 2'd0;  // command on write
	localparam fdc_addr_t reg_track  = 2'd1;
	localparam fdc_addr_t reg_sector = 2'd2;
	localparam fdc_addr_t reg_data   = 2'd3;

	localparam logic [3:0] cmd_restore   = 4'h0;
	localparam logic [3:0] cmd_seek      = 4'h1;
	localparam logic [3:0] cmd_read      = 4'h8;
	localparam logic [3:0] cmd_write     = 4'hA;
	localparam logic [3:0] cmd_force_int = 4'hD;

	localparam int default_delay_cycles = 4000;
	localparam int default_lost_cycles  = 4096;

	// sectors per track for each geometry select
	function automatic fdc_byte_t spt_of(input size_sel_t sel);
		case (sel)
			3'd0:    return 8'd26;
			3'd1:    return 8'd17;
			3'd3:    return 8'd5;
			3'd4:    return 8'd10;
			default: return 8'd9;
		endcase
	endfunction

	// sector size is 128 << size code
	function automatic logic [1:0] size_code_of(input size_sel_t sel);
		case (sel)
			3'd0:    return 2'd0;
			3'd1:    return 2'd1;
			3'd3:    return 2'd3;
			default: return 2'd2;
		endcase
	endfunction

	typedef enum logic [3:0] {
		st_idle, st_search, st_load_blk, st_load_wait, st_xfer_arm, st_xfer_wait,
		st_xfer_byte, st_store_blk, st_store_wait, st_delay, st_end_cmd
	} ctrl_state_t;

	typedef enum logic [1:0] {sd_idle, sd_request, sd_wait_ack} sd_state_t;

endpackage

//--- logic/fdc_ifs.sv
// internal links of the floppy controller
// command path between host port and controller, block path to the SD sequencer
`timescale 1ns/1ns

interface fdc_cmd_if;
	logic               cmd_stb;     // one cycle, command written
	fdc_pkg::fdc_byte_t cmd_byte;
	fdc_pkg::fdc_byte_t data_reg;
	fdc_pkg::fdc_byte_t sector_reg;
	logic               rd_done;     // host consumed data byte
	logic               wr_done;     // host supplied data byte
	logic               busy;
	logic               drq;
	logic [7:1]         status_flags;
	logic               track_ld;
	fdc_pkg::fdc_byte_t track_val;
	logic               sector_inc;
	logic               sector_one;
	logic               cmd_done;

	modport host (output cmd_stb, cmd_byte, data_reg, sector_reg, rd_done, wr_done,
		input busy, drq, status_flags, track_ld, track_val, sector_inc, sector_one, cmd_done);
	modport ctrl (input cmd_stb, cmd_byte, data_reg, sector_reg, rd_done, wr_done,
		output busy, drq, status_flags, track_ld, track_val, sector_inc, sector_one, cmd_done);
endinterface

interface fdc_sd_if;
	logic                start;     // pulse, run blocks 0..blk_last
	logic                write;
	fdc_pkg::lba_t       lba_base;
	fdc_pkg::blk_idx_t   blk_last;
	fdc_pkg::blk_idx_t   blk;
	logic                done;

	modport ctrl (output start, write, lba_base, blk_last, input blk, done);
	modport seq  (input start, write, lba_base, blk_last, output blk, done);
endinterface

//--- logic/fdc_host_port.sv
// fdc_host_port
// host bus side: strobe edges, track/sector/data registers,
// interrupt flag and read mux
`timescale 1ns/1ns

module fdc_host_port (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               rd,
	input  logic               wr,
	input  fdc_pkg::fdc_addr_t addr,
	input  fdc_pkg::fdc_byte_t din,
	input  fdc_pkg::fdc_byte_t buf_rdata,
	input  logic               xfer_rd,
	output fdc_pkg::fdc_byte_t dout,
	output logic               intrq,
	fdc_cmd_if.host            cmd
);

	logic               old_rd, old_wr;
	fdc_pkg::fdc_addr_t cur_addr;    // address seen at strobe rise
	fdc_pkg::fdc_byte_t track_reg;
	logic               wr_rise, rd_rise, rd_fall, wr_fall;

	assign wr_rise = wr & ~old_wr;
	assign rd_rise = rd & ~old_rd;
	assign rd_fall = old_rd & ~rd;
	assign wr_fall = old_wr & ~wr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			old_rd         <= 1'b0;
			old_wr         <= 1'b0;
			cur_addr       <= fdc_pkg::reg_status;
			cmd.cmd_stb    <= 1'b0;
			cmd.rd_done    <= 1'b0;
			cmd.wr_done    <= 1'b0;
			track_reg      <= '0;
			cmd.sector_reg <= 8'd1;
			cmd.data_reg   <= '0;
			intrq          <= 1'b0;
		end else begin
			old_rd <= rd;
			old_wr <= wr;
			if (rd_rise || wr_rise)
				cur_addr <= addr;

			cmd.cmd_stb <= wr_rise && (addr == fdc_pkg::reg_status);
			cmd.rd_done <= rd_fall && (cur_addr == fdc_pkg::reg_data);
			cmd.wr_done <= wr_fall && (cur_addr == fdc_pkg::reg_data);

			// controller updates first, host writes win while idle
			if (cmd.track_ld)
				track_reg <= cmd.track_val;
			if (cmd.sector_one)
				cmd.sector_reg <= 8'd1;
			else if (cmd.sector_inc)
				cmd.sector_reg <= cmd.sector_reg + 8'd1;

			if (wr_rise) begin
				case (addr)
					fdc_pkg::reg_track:  if (!cmd.busy) track_reg <= din;
					fdc_pkg::reg_sector: if (!cmd.busy) cmd.sector_reg <= din;
					fdc_pkg::reg_data:   cmd.data_reg <= din;
					default: ;
				endcase
			end

			if (cmd.cmd_done)
				intrq <= 1'b1;
			if (cmd.cmd_stb || (rd_fall && cur_addr == fdc_pkg::reg_status))
				intrq <= 1'b0;  // cleared by new command or status read
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_rise && addr == fdc_pkg::reg_status)
			cmd.cmd_byte <= din;
	end

	always_comb begin
		case (addr)
			fdc_pkg::reg_status: dout = {cmd.status_flags, cmd.busy};
			fdc_pkg::reg_track:  dout = track_reg;
			fdc_pkg::reg_sector: dout = cmd.sector_reg;
			default:             dout = xfer_rd ? buf_rdata : cmd.data_reg;
		endcase
	end

	// controller register updates only arrive while a command runs
	a_ctrl_upd_busy: assert property (@(posedge clk_sys) disable iff (rst)
		(cmd.track_ld || cmd.sector_inc || cmd.sector_one) |-> cmd.busy);

endmodule

//--- logic/fdc_cmd_ctrl.sv
// fdc_cmd_ctrl
// command FSM: type I head moves, sector read/write through the SD
// block sequencer, force interrupt, status byte and lost-data watchdog
`timescale 1ns/1ns

module fdc_cmd_ctrl #(
	parameter int delay_cycles = fdc_pkg::default_delay_cycles,
	parameter int lost_cycles  = fdc_pkg::default_lost_cycles
) (
	input  logic               clk_sys,
	input  logic               rst,
	input  logic               wp,
	input  logic               ready,
	input  logic               side,
	input  fdc_pkg::size_sel_t size_code,
	output fdc_pkg::buf_addr_t buf_addr,
	output fdc_pkg::fdc_byte_t buf_wdata,
	output logic               buf_we,
	input  fdc_pkg::fdc_byte_t buf_rdata,
	output logic               xfer_rd,
	fdc_cmd_if.ctrl            cmd,
	fdc_sd_if.ctrl             sd
);

	localparam int dw = $clog2(delay_cycles + 1);
	localparam int ww = $clog2(lost_cycles + 1);

	fdc_pkg::ctrl_state_t state;
	logic [dw-1:0] delay_cnt;
	logic [ww-1:0] wd_cnt;
	logic headloaded, seekerr, lostdata, wrfault, cmd_mode, wpe;
	logic step_dir, write_f, multi, we_pend;
	fdc_pkg::fdc_byte_t disk_track, next_track, spt;
	fdc_pkg::buf_addr_t byte_addr;
	fdc_pkg::byte_cnt_t byte_cnt;
	fdc_pkg::img_addr_t sec_idx, img_off;
	logic [1:0] szc;
	logic [3:0] nib;
	logic sec_done, last_byte;

	// ==================================================================
	// fixed geometry address
	// ==================================================================
	assign spt     = fdc_pkg::spt_of(size_code);
	assign szc     = fdc_pkg::size_code_of(size_code);
	assign sec_idx = fdc_pkg::img_addr_t'({disk_track, side}) * fdc_pkg::img_addr_t'(spt)
		+ fdc_pkg::img_addr_t'(cmd.sector_reg) - 20'd1;
	assign img_off = (sec_idx << 7) << szc;

	assign nib        = cmd.cmd_byte[7:4];
	assign next_track = (cmd.cmd_byte[6] ? cmd.cmd_byte[5] : step_dir) ?
		disk_track - 8'd1 : disk_track + 8'd1;
	assign last_byte  = (byte_cnt == 11'd1);
	assign sec_done   = (state == fdc_pkg::st_xfer_byte && last_byte && !write_f) ||
		(state == fdc_pkg::st_store_wait && sd.done);

	assign cmd.sector_inc = sec_done & multi;
	assign cmd.cmd_done   = (state == fdc_pkg::st_end_cmd);
	assign cmd.status_flags = cmd_mode ?
		{~ready, wp & wpe, wrfault, seekerr | ~ready, 1'b0, lostdata, cmd.drq} :
		{~ready, wp & wpe, headloaded, seekerr | ~ready, 1'b0, disk_track == 8'd0, 1'b0};

	assign buf_addr  = byte_addr;
	assign buf_wdata = cmd.data_reg;
	assign buf_we    = (state == fdc_pkg::st_xfer_byte) && we_pend;
	assign xfer_rd   = !write_f && (state == fdc_pkg::st_xfer_arm ||
		state == fdc_pkg::st_xfer_wait || state == fdc_pkg::st_xfer_byte);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state  <= fdc_pkg::st_idle;
			{cmd.busy, cmd.drq, cmd.track_ld, cmd.sector_one, sd.start, sd.write} <= '0;
			{headloaded, seekerr, lostdata, wrfault, step_dir, write_f, multi} <= '0;
			cmd_mode   <= 1'b1;  // type II view, status reads 0
			wpe        <= 1'b1;
			we_pend    <= 1'b0;
			disk_track <= '0;
			delay_cnt  <= '0;
			wd_cnt     <= '0;
		end else begin
			cmd.track_ld   <= 1'b0;
			cmd.sector_one <= 1'b0;
			sd.start       <= 1'b0;
			if (wd_cnt != '0)
				wd_cnt <= wd_cnt - 1'b1;

			case (state)
				fdc_pkg::st_search: begin
					if (!ready || cmd.sector_reg == 8'd0 || cmd.sector_reg > spt) begin
						seekerr        <= 1'b1;
						cmd.sector_one <= multi && ready && cmd.sector_reg != 8'd0;  // wrap
						state          <= fdc_pkg::st_end_cmd;
					end else begin
						sd.lba_base <= fdc_pkg::lba_t'(img_off[19:9]);
						case (szc)
							2'd2:    sd.blk_last <= (img_off[8:0] != 9'd0) ? 2'd1 : 2'd0;
							2'd3:    sd.blk_last <= (img_off[8:0] != 9'd0) ? 2'd2 : 2'd1;
							default: sd.blk_last <= 2'd0;
						endcase
						byte_addr <= fdc_pkg::buf_addr_t'(img_off[8:0]);
						byte_cnt  <= fdc_pkg::byte_cnt_t'(11'd128 << szc);
						state     <= fdc_pkg::st_load_blk;
					end
				end
				fdc_pkg::st_load_blk: begin  // read first, also before a write
					sd.start <= 1'b1;
					sd.write <= 1'b0;
					state    <= fdc_pkg::st_load_wait;
				end
				fdc_pkg::st_load_wait:
					if (sd.done) state <= fdc_pkg::st_xfer_arm;
				fdc_pkg::st_xfer_arm: begin
					wd_cnt   <= ww'(lost_cycles);
					we_pend  <= 1'b0;
					cmd.drq  <= 1'b1;
					state    <= fdc_pkg::st_xfer_wait;
				end
				fdc_pkg::st_xfer_wait: begin
					if (wd_cnt == '0) begin
						lostdata <= 1'b1;  // byte dropped
						cmd.drq  <= 1'b0;
						state    <= fdc_pkg::st_xfer_byte;
					end else if (write_f ? cmd.wr_done : cmd.rd_done) begin
						we_pend <= write_f;
						cmd.drq <= 1'b0;
						state   <= fdc_pkg::st_xfer_byte;
					end
				end
				fdc_pkg::st_xfer_byte: begin
					byte_addr <= byte_addr + 11'd1;
					byte_cnt  <= byte_cnt - 11'd1;
					we_pend   <= 1'b0;
					if (!last_byte)
						state <= fdc_pkg::st_xfer_arm;
					else if (write_f)
						state <= fdc_pkg::st_store_blk;
					else
						state <= multi ? fdc_pkg::st_search : fdc_pkg::st_end_cmd;
				end
				fdc_pkg::st_store_blk: begin
					sd.start <= 1'b1;
					sd.write <= 1'b1;
					state    <= fdc_pkg::st_store_wait;
				end
				fdc_pkg::st_store_wait:
					if (sd.done) state <= multi ? fdc_pkg::st_search : fdc_pkg::st_end_cmd;
				fdc_pkg::st_delay:
					if (delay_cnt == '0) state <= fdc_pkg::st_end_cmd;
					else delay_cnt <= delay_cnt - 1'b1;
				fdc_pkg::st_end_cmd: begin
					cmd.busy <= 1'b0;
					cmd.drq  <= 1'b0;
					state    <= fdc_pkg::st_idle;
				end
				default: ;
			endcase

			// ==============================================================
			// command decode
			// ==============================================================
			if (cmd.cmd_stb && nib == fdc_pkg::cmd_force_int) begin
				cmd_mode <= 1'b0;
				{seekerr, lostdata, wrfault, cmd.drq} <= '0;
				if (state != fdc_pkg::st_idle) state <= fdc_pkg::st_end_cmd;
				else cmd.busy <= 1'b0;
			end else if (cmd.cmd_stb && state == fdc_pkg::st_idle) begin
				cmd_mode  <= cmd.cmd_byte[7];
				wpe       <= ~cmd.cmd_byte[7];
				cmd.busy  <= 1'b1;
				delay_cnt <= dw'(delay_cycles);
				state     <= fdc_pkg::st_delay;
				if (nib[3] == 1'b0) begin
					headloaded <= cmd.cmd_byte[3];
					if (nib == fdc_pkg::cmd_restore) begin
						disk_track    <= '0;
						cmd.track_ld  <= 1'b1;
						cmd.track_val <= '0;
					end else if (nib == fdc_pkg::cmd_seek) begin
						disk_track <= cmd.data_reg;
					end else begin
						if (cmd.cmd_byte[6]) step_dir <= cmd.cmd_byte[5];
						disk_track    <= next_track;
						cmd.track_ld  <= cmd.cmd_byte[4];
						cmd.track_val <= next_track;
					end
				end else if ((nib & 4'hE) == fdc_pkg::cmd_read ||
					(nib & 4'hE) == fdc_pkg::cmd_write) begin
					{seekerr, lostdata, wrfault} <= '0;
					write_f <= cmd.cmd_byte[5];
					wpe     <= cmd.cmd_byte[5];
					multi   <= cmd.cmd_byte[4];
					if (wp && cmd.cmd_byte[5])
						wrfault <= 1'b1;  // protected, no SD access
					else
						state <= fdc_pkg::st_search;
				end
			end
		end
	end

	a_drq_busy: assert property (@(posedge clk_sys) disable iff (rst) cmd.drq |-> cmd.busy);
	a_we_after_drq: assert property (@(posedge clk_sys) disable iff (rst)
		buf_we |-> write_f && $past(cmd.drq));

endmodule

//--- logic/fdc_sector_buf.sv
// fdc_sector_buf
// 2 KiB true dual-port byte buffer, SD card on one side and the
// controller on the other, writes read back the new byte
`timescale 1ns/1ns

module fdc_sector_buf (
	input  logic               clk_sys,
	input  fdc_pkg::buf_addr_t sd_addr,
	input  fdc_pkg::fdc_byte_t sd_wdata,
	input  logic               sd_we,
	output fdc_pkg::fdc_byte_t sd_rdata,
	input  fdc_pkg::buf_addr_t ctl_addr,
	input  fdc_pkg::fdc_byte_t ctl_wdata,
	input  logic               ctl_we,
	output fdc_pkg::fdc_byte_t ctl_rdata
);

	fdc_pkg::fdc_byte_t mem [0:2047];

	always_ff @(posedge clk_sys) begin
		if (sd_we) begin
			mem[sd_addr] <= sd_wdata;
			sd_rdata     <= sd_wdata;
		end else
			sd_rdata <= mem[sd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (ctl_we) begin
			mem[ctl_addr] <= ctl_wdata;
			ctl_rdata     <= ctl_wdata;
		end else
			ctl_rdata <= mem[ctl_addr];
	end

	a_no_write_clash: assert property (@(posedge clk_sys)
		!(sd_we && ctl_we && sd_addr == ctl_addr));

endmodule

//--- logic/fdc_sd_blocks.sv
// fdc_sd_blocks
// requests SD blocks lba_base+0 .. lba_base+blk_last, one at a time,
// with a synchronized ack handshake
`timescale 1ns/1ns

module fdc_sd_blocks (
	input  logic          clk_sys,
	input  logic          rst,
	input  logic          sd_ack,
	output logic          sd_rd,
	output logic          sd_wr,
	output fdc_pkg::lba_t sd_lba,
	input  logic          sd_buff_wr,
	output logic          sd_we_gated,
	fdc_sd_if.seq         sd
);

	fdc_pkg::sd_state_t state;
	logic [1:0] ack_s;  // ack synchronizer

	assign sd_lba      = sd.lba_base + fdc_pkg::lba_t'(sd.blk);
	assign sd_we_gated = sd_buff_wr & sd_ack;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state   <= fdc_pkg::sd_idle;
			ack_s   <= '0;
			sd_rd   <= 1'b0;
			sd_wr   <= 1'b0;
			sd.blk  <= '0;
			sd.done <= 1'b0;
		end else begin
			ack_s   <= {ack_s[0], sd_ack};
			sd.done <= 1'b0;
			case (state)
				fdc_pkg::sd_idle:
					if (sd.start) begin
						sd.blk <= '0;
						state  <= fdc_pkg::sd_request;
					end
				fdc_pkg::sd_request:
					if (!ack_s[1]) begin  // previous ack gone
						sd_rd <= ~sd.write;
						sd_wr <= sd.write;
						state <= fdc_pkg::sd_wait_ack;
					end
				default:
					if (sd_rd || sd_wr) begin
						if (ack_s[1]) {sd_rd, sd_wr} <= 2'b00;
					end else if (!ack_s[1]) begin
						if (sd.blk == sd.blk_last) begin
							sd.done <= 1'b1;
							state   <= fdc_pkg::sd_idle;
						end else begin
							sd.blk <= sd.blk + 2'd1;
							state  <= fdc_pkg::sd_request;
						end
					end
			endcase
		end
	end

	// card writes into the buffer only inside a block read
	a_buff_wr_on_read: assert property (@(posedge clk_sys) disable iff (rst)
		sd_we_gated |-> (state == fdc_pkg::sd_wait_ack) && !sd.write);

endmodule

//--- logic/fdc_top.sv
// fdc_top
// WD1793-style floppy controller with the disk image on an SD card,
// host register port, command FSM, sector buffer and SD block sequencer
`timescale 1ns/1ns

module fdc_top #(
	parameter int delay_cycles = fdc_pkg::default_delay_cycles,
	parameter int lost_cycles  = fdc_pkg::default_lost_cycles
) (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                rd,
	input  logic                wr,
	input  fdc_pkg::fdc_addr_t  addr,
	input  fdc_pkg::fdc_byte_t  din,
	output fdc_pkg::fdc_byte_t  dout,
	output logic                drq,
	output logic                intrq,
	output logic                busy,
	input  logic                wp,
	input  logic                ready,
	input  logic                side,
	input  fdc_pkg::size_sel_t  size_code,
	output fdc_pkg::lba_t       sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	input  logic                sd_ack,
	input  fdc_pkg::sd_off_t    sd_buff_addr,
	input  fdc_pkg::fdc_byte_t  sd_buff_dout,
	output fdc_pkg::fdc_byte_t  sd_buff_din,
	input  logic                sd_buff_wr
);

	fdc_cmd_if cmd ();
	fdc_sd_if  sd ();

	fdc_pkg::buf_addr_t buf_addr;
	fdc_pkg::fdc_byte_t buf_wdata;
	fdc_pkg::fdc_byte_t buf_rdata;
	logic               buf_we;
	logic               xfer_rd;
	logic               sd_we_gated;

	assign drq  = cmd.drq;
	assign busy = cmd.busy;

	fdc_host_port host_i (
		.clk_sys, .rst, .rd, .wr, .addr, .din,
		.buf_rdata, .xfer_rd, .dout, .intrq,
		.cmd (cmd.host)
	);

	fdc_cmd_ctrl #(.delay_cycles(delay_cycles), .lost_cycles(lost_cycles)) ctrl_i (
		.clk_sys, .rst, .wp, .ready, .side, .size_code,
		.buf_addr, .buf_wdata, .buf_we, .buf_rdata, .xfer_rd,
		.cmd (cmd.ctrl),
		.sd  (sd.ctrl)
	);

	// block index selects the 512-byte slot of the buffer
	fdc_sector_buf buf_i (
		.clk_sys,
		.sd_addr   ({sd.blk, sd_buff_addr}),
		.sd_wdata  (sd_buff_dout),
		.sd_we     (sd_we_gated),
		.sd_rdata  (sd_buff_din),
		.ctl_addr  (buf_addr),
		.ctl_wdata (buf_wdata),
		.ctl_we    (buf_we),
		.ctl_rdata (buf_rdata)
	);

	fdc_sd_blocks sd_i (
		.clk_sys, .rst, .sd_ack, .sd_rd, .sd_wr, .sd_lba,
		.sd_buff_wr, .sd_we_gated,
		.sd (sd.seq)
	);

endmodule

//--- bench/fdc_clk_gen.sv
// fdc_clk_gen
// bench clock (100 ns period) and synchronous reset held for two cycles
`timescale 1ns/1ns

module fdc_clk_gen (
	output logic clk_sys,
	output logic rst
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;
	end

endmodule

//--- bench/fdc_sd_model.sv
// fdc_sd_model
// behavioral SD card: 64 KiB image, answers block reads and writes
// a few cycles late through the sd_buff_* port
`timescale 1ns/1ns

module fdc_sd_model #(
	parameter int resp_delay = 3
) (
	input  logic               clk_sys,
	input  logic               sd_rd,
	input  logic               sd_wr,
	input  fdc_pkg::lba_t      sd_lba,
	output logic               sd_ack,
	output fdc_pkg::sd_off_t   sd_buff_addr,
	output fdc_pkg::fdc_byte_t sd_buff_dout,
	input  fdc_pkg::fdc_byte_t sd_buff_din,
	output logic               sd_buff_wr,
	output fdc_pkg::lba_t      last_lba
);

	logic [7:0] img [0:65535];

	task automatic serve_block(input logic is_write, input fdc_pkg::lba_t lba);
		logic [15:0] base;
		int i;
		base = {lba[6:0], 9'd0};  // 128 blocks fit the image
		repeat (resp_delay) @(posedge clk_sys);
		last_lba <= lba;
		sd_ack   <= 1'b1;
		for (i = 0; i < 512; i++) begin
			sd_buff_addr <= 9'(i);
			if (!is_write) begin
				sd_buff_dout <= img[base + 16'(i)];
				sd_buff_wr   <= 1'b1;
				@(posedge clk_sys);
			end else begin
				@(posedge clk_sys);
				@(negedge clk_sys);  // buffer read has one cycle latency
				img[base + 16'(i)] = sd_buff_din;
				@(posedge clk_sys);
			end
		end
		sd_buff_wr <= 1'b0;
		sd_ack     <= 1'b0;
	endtask

	initial begin
		int i;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		last_lba     = '0;
		for (i = 0; i < 65536; i++)
			img[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr)
				serve_block(sd_wr, sd_lba);
		end
	end

endmodule

//--- bench/fdc_tb.sv
// fdc_tb
// testbench for the floppy controller: register access, type I moves,
// sector write and read through the SD model, write protect, force interrupt
`timescale 1ns/1ns

module fdc_tb;

	localparam int max_cycles = 40000;  // about five times the longest test sequence
	localparam int spt_sz1    = 17;     // size select 1: 17 sectors of 256 bytes
	localparam int sec_bytes  = 256;

	logic clk_sys, rst;
	logic rd, wr, drq, intrq, busy, wp, ready, side, sd_rd, sd_wr, sd_ack, sd_buff_wr;
	fdc_pkg::fdc_addr_t addr;
	fdc_pkg::fdc_byte_t din, dout, sd_buff_dout, sd_buff_din;
	fdc_pkg::size_sel_t size_code;
	fdc_pkg::lba_t      sd_lba, last_lba;
	fdc_pkg::sd_off_t   sd_buff_addr;

	fdc_pkg::fdc_byte_t wbuf [0:sec_bytes-1];
	string test_name = "reset";
	int    check_errs = 0;
	int    assert_errs = 0;
	int    cycles = 0;
	logic  wp_phase = 1'b0;

	fdc_clk_gen clk_gen_i (.clk_sys, .rst);

	fdc_sd_model sd_model_i (
		.clk_sys, .sd_rd, .sd_wr, .sd_lba, .sd_ack, .sd_buff_addr,
		.sd_buff_dout, .sd_buff_din, .sd_buff_wr, .last_lba
	);

	fdc_top #(.delay_cycles(20), .lost_cycles(64)) fdc_top_i (
		.clk_sys, .rst, .rd, .wr, .addr, .din, .dout, .drq, .intrq, .busy,
		.wp, .ready, .side, .size_code, .sd_lba, .sd_rd, .sd_wr, .sd_ack,
		.sd_buff_addr, .sd_buff_dout, .sd_buff_din, .sd_buff_wr
	);

	// ======================================================================
	// host bus tasks
	// ======================================================================
	task automatic write_reg(input fdc_pkg::fdc_addr_t a, input fdc_pkg::fdc_byte_t d);
		@(posedge clk_sys);
		addr <= a;
		din  <= d;
		wr   <= 1'b1;
		@(posedge clk_sys);
		wr <= 1'b0;
		@(posedge clk_sys);  // falling edge seen here
	endtask

	task automatic read_reg(input fdc_pkg::fdc_addr_t a, output fdc_pkg::fdc_byte_t d);
		@(posedge clk_sys);
		addr <= a;
		rd   <= 1'b1;
		@(negedge clk_sys);
		d = dout;
		@(posedge clk_sys);
		rd <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic wait_drq(input logic level);
		@(negedge clk_sys);
		while (drq !== level) @(negedge clk_sys);
	endtask

	task automatic wait_intrq();
		@(negedge clk_sys);
		while (intrq !== 1'b1) @(negedge clk_sys);
	endtask

	task automatic check_eq(input string what, input int exp, input int act);
		assert (act == exp) else begin
			check_errs++;
			$display("CHECK FAILED %s %s expected 0x%0h actual 0x%0h",
				test_name, what, exp, act);
		end
	endtask

	// ======================================================================
	// properties over the whole run
	// ======================================================================
	a_drq_needs_busy: assert property (@(posedge clk_sys) disable iff (rst) drq |-> busy)
	else begin
		assert_errs++;
		$display("CHECK FAILED %s drq high while idle expected busy 1 actual 0", test_name);
	end

	a_no_sd_write_protected: assert property (@(posedge clk_sys) disable iff (rst)
		wp_phase |-> !sd_wr)
	else begin
		assert_errs++;
		$display("CHECK FAILED %s sd_wr under write protect expected 0 actual 1", test_name);
	end

	a_intrq_when_idle: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(intrq) |-> !busy)
	else begin
		assert_errs++;
		$display("CHECK FAILED %s busy at interrupt expected 0 actual 1", test_name);
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("timeout in test %s after %0d cycles", test_name, max_cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		fdc_pkg::fdc_byte_t st, b;
		int off, i;
		void'($urandom(67452));
		rd        <= 1'b0;
		wr        <= 1'b0;
		addr      <= fdc_pkg::reg_status;
		din       <= '0;
		wp        <= 1'b0;
		ready     <= 1'b1;
		side      <= 1'b0;
		size_code <= 3'd1;
		@(negedge clk_sys);
		while (rst) @(negedge clk_sys);

		check_eq("busy", 0, busy);
		check_eq("drq", 0, drq);
		check_eq("intrq", 0, intrq);
		read_reg(fdc_pkg::reg_status, st);
		check_eq("status", 0, st);
		read_reg(fdc_pkg::reg_sector, b);
		check_eq("sector reg", 1, b);
		write_reg(fdc_pkg::reg_track, 8'h2A);
		read_reg(fdc_pkg::reg_track, b);
		check_eq("track reg", 8'h2A, b);
		write_reg(fdc_pkg::reg_sector, 8'h07);
		read_reg(fdc_pkg::reg_sector, b);
		check_eq("sector reg", 8'h07, b);

		test_name = "restore_seek";
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_restore, 4'h0});
		@(negedge clk_sys);
		check_eq("busy after restore", 1, busy);
		wait_intrq();
		check_eq("busy at end", 0, busy);
		read_reg(fdc_pkg::reg_status, st);
		check_eq("track0 after restore", 1, st[2]);
		@(negedge clk_sys);
		check_eq("intrq after status read", 0, intrq);
		read_reg(fdc_pkg::reg_track, b);
		check_eq("track reg after restore", 0, b);
		write_reg(fdc_pkg::reg_data, 8'd5);
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_seek, 4'h0});
		@(negedge clk_sys);
		check_eq("busy after seek", 1, busy);
		wait_intrq();
		check_eq("busy at end", 0, busy);
		read_reg(fdc_pkg::reg_status, st);
		check_eq("track0 after seek", 0, st[2]);

		// track 5, side 1, sector 3 with 17 sectors of 256 bytes
		test_name = "write_sector";
		off = ((5 * 2 + 1) * spt_sz1 + 3 - 1) * sec_bytes;
		@(posedge clk_sys);
		side      <= 1'b1;
		size_code <= 3'd1;
		write_reg(fdc_pkg::reg_sector, 8'd3);
		for (i = 0; i < sec_bytes; i++)
			wbuf[i] = 8'($urandom);
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_write, 4'h0});
		for (i = 0; i < sec_bytes; i++) begin
			wait_drq(1'b1);
			write_reg(fdc_pkg::reg_data, wbuf[i]);
			wait_drq(1'b0);
		end
		wait_intrq();
		check_eq("busy at end", 0, busy);
		read_reg(fdc_pkg::reg_status, st);
		check_eq("lost data or seek error", 0, st & 8'h14);
		for (i = 0; i < sec_bytes; i++)
			check_eq($sformatf("image byte %0d", i), wbuf[i], sd_model_i.img[off + i]);
		check_eq("served lba", off / 512, last_lba);

		test_name = "read_sector";
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_read, 4'h0});
		for (i = 0; i < sec_bytes; i++) begin
			wait_drq(1'b1);
			read_reg(fdc_pkg::reg_data, b);
			check_eq($sformatf("data byte %0d", i), sd_model_i.img[off + i], b);
			wait_drq(1'b0);
		end
		wait_intrq();
		check_eq("busy at end", 0, busy);
		read_reg(fdc_pkg::reg_status, st);
		check_eq("lost data", 0, st[2]);
		check_eq("seek error", 0, st[4]);

		test_name = "write_protect";
		@(posedge clk_sys);
		wp       <= 1'b1;
		wp_phase <= 1'b1;
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_write, 4'h0});
		wait_intrq();
		check_eq("busy at end", 0, busy);
		read_reg(fdc_pkg::reg_status, st);
		check_eq("wp and write fault", 2'b11, st[6:5]);
		@(posedge clk_sys);
		wp       <= 1'b0;
		wp_phase <= 1'b0;

		test_name = "force_int";
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_read, 4'h0});
		wait_drq(1'b1);
		read_reg(fdc_pkg::reg_data, b);
		wait_drq(1'b0);
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_force_int, 4'h0});
		wait_intrq();
		check_eq("busy after abort", 0, busy);
		check_eq("drq after abort", 0, drq);
		read_reg(fdc_pkg::reg_status, st);

		test_name = "sector_zero";
		write_reg(fdc_pkg::reg_sector, 8'd0);
		write_reg(fdc_pkg::reg_status, {fdc_pkg::cmd_read, 4'h0});
		wait_intrq();
		read_reg(fdc_pkg::reg_status, st);
		check_eq("seek error", 1, st[4]);

		repeat (4) @(posedge clk_sys);
		$display("errors: checks %0d, assertions %0d", check_errs, assert_errs);
		if (check_errs == 0 && assert_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
logic/fdc_pkg.sv
logic/fdc_ifs.sv
logic/fdc_host_port.sv
logic/fdc_cmd_ctrl.sv
logic/fdc_sector_buf.sv
logic/fdc_sd_blocks.sv
logic/fdc_top.sv
bench/fdc_clk_gen.sv
bench/fdc_sd_model.sv
bench/fdc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the floppy controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fdc_tb -f verilog.f -o fdc_sim

out=$(./obj_dir/fdc_sim)
echo "$out"
echo "$out" | grep -q "STATUS: PASS"
